// ==== frontend_pkg.sv ====
// Shared widths, instruction fields and payload types of the front end.
// One instruction per group, so a group and an instruction are the same word.

package frontend_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// Fetch address and instruction group widths
	localparam int unsigned addr_w = 32;
	localparam int unsigned group_w = 32;

	// The fetch address steps by one group at a time
	localparam int unsigned group_bytes = 4;

	// ========================================================================
	// Instruction fields
	// ========================================================================

	// The opcode sits in the low bits of the group
	localparam int unsigned opcode_lsb = 0;
	localparam int unsigned opcode_w = 7;

	// A call carries a word displacement in the bits above the opcode
	localparam int unsigned disp_lsb = 7;
	localparam int unsigned disp_w = 25;

	// Unconditional subroutine call
	localparam logic [opcode_w-1:0] op_bsr = 7'h21;

	// ========================================================================
	// Types
	// ========================================================================

	// The order matters because recovery is tested as a range of values
	typedef enum logic [2:0] {
		bs_idle,
		bs_chkpt_restore,
		bs_done1,
		bs_done2
	} branch_state_t;

	// Payload of the mux and decode stages
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [group_w-1:0] group;
	} fetch_packet_t;

	// Payload of the rename stage, which also knows whether the group was a call
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [group_w-1:0] group;
		logic is_call;
	} rename_packet_t;

endpackage

// ==== fetch_stage.sv ====
// Fetch address register. A branch miss redirects at once, a call only on an advance,
// and a plain step needs both an advance and a cache hit.
`timescale 1ns/1ps

module fetch_stage #(
	parameter logic [frontend_pkg::addr_w-1:0] reset_addr = '0
) (
	input  logic clk,
	input  logic rst,
	input  logic advance_pipeline,
	input  logic ihit,
	input  logic do_bsr,
	input  logic [frontend_pkg::addr_w-1:0] bsr_target,
	input  logic branchmiss,
	input  logic [frontend_pkg::addr_w-1:0] branch_target,
	output logic [frontend_pkg::addr_w-1:0] fetch_addr
);

	// Address of the group after the one being fetched now
	logic [frontend_pkg::addr_w-1:0] next_seq_addr;

	// The step is a constant so this is only an adder on the low bits
	assign next_seq_addr = fetch_addr + frontend_pkg::addr_w'(frontend_pkg::group_bytes);

	// ========================================================================
	// Fetch address
	// ========================================================================

	// A branch miss comes from the back end and must not wait for the
	// front end to advance. Otherwise the pipeline could sit on a stall
	// and keep fetching down the wrong path
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_addr <= reset_addr;
		end else if (branchmiss) begin
			fetch_addr <= branch_target;
		end else if (advance_pipeline) begin
			// The call sits in decode, two groups ahead of fetch.
			// Its target replaces whatever the sequential path would be
			if (do_bsr) begin
				fetch_addr <= bsr_target;
			end else if (ihit) begin
				fetch_addr <= next_seq_addr;
			end
			// On a miss the address holds so the same group is asked for again
		end
	end

endmodule

// ==== branch_recovery_fsm.sv ====
// Checkpoint restore sequencer. It always takes three cycles after the last branch
// miss, and a miss during recovery starts the walk over.
`timescale 1ns/1ps

module branch_recovery_fsm (
	input  logic clk,
	input  logic rst,
	input  logic branchmiss,
	output frontend_pkg::branch_state_t branch_state
);

	// Next state, worked out from the current state and the miss strobe
	frontend_pkg::branch_state_t next_state;

	// ========================================================================
	// Next state
	// ========================================================================

	always_comb begin
		next_state = branch_state;
		if (branchmiss) begin
			// Any miss, even one in the middle of recovery, restores the
			// checkpoint again because the older restore is now stale
			next_state = frontend_pkg::bs_chkpt_restore;
		end else begin
			case (branch_state)
				frontend_pkg::bs_idle: begin
					next_state = frontend_pkg::bs_idle;
				end
				// The register map is being restored from the checkpoint
				frontend_pkg::bs_chkpt_restore: begin
					next_state = frontend_pkg::bs_done1;
				end
				// Two settle cycles let groups already renamed drain as copy targets
				frontend_pkg::bs_done1: begin
					next_state = frontend_pkg::bs_done2;
				end
				frontend_pkg::bs_done2: begin
					next_state = frontend_pkg::bs_idle;
				end
				// Codes outside the four states fall back to idle
				default: begin
					next_state = frontend_pkg::bs_idle;
				end
			endcase
		end
	end

	// ========================================================================
	// State register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			branch_state <= frontend_pkg::bs_idle;
		end else begin
			branch_state <= next_state;
		end
	end

endmodule

// ==== stomp_unit.sv ====
// Stomp waterfall and call detection. A call is recognized only in the decode stage
// and only when that stage holds a live group.
`timescale 1ns/1ps

module stomp_unit (
	input  logic clk,
	input  logic rst,
	input  logic ihit,
	input  logic advance_pipeline,
	input  logic advance_pipeline_seg2,
	input  logic micro_code_active,
	input  logic branchmiss,
	input  frontend_pkg::branch_state_t branch_state,
	input  logic [frontend_pkg::opcode_w-1:0] dec_opcode,
	input  logic [frontend_pkg::addr_w-1:0] dec_addr,
	input  logic [frontend_pkg::group_w-1:0] dec_group,
	output logic do_bsr,
	output logic [frontend_pkg::addr_w-1:0] bsr_target,
	output logic stomp_mux,
	output logic stomp_dec,
	output logic stomp_ren,
	output logic stomp_que,
	output logic stomp_quem
);

	// Sign bits needed to widen the word displacement to a byte offset
	localparam int unsigned ext_w = frontend_pkg::addr_w - frontend_pkg::disp_w - 2;

	// Combinational kill terms
	logic stomp_fet;
	logic in_recovery;
	logic [frontend_pkg::addr_w-1:0] bsr_disp;

	// Next values of the registered flags
	logic next_stomp_mux;
	logic next_stomp_dec;
	logic next_stomp_ren;
	logic next_stomp_quem;

	// ========================================================================
	// Call detection
	// ========================================================================

	// A stomped group in decode is wrong-path, so a call there must not redirect
	assign do_bsr = (dec_opcode == frontend_pkg::op_bsr) && !stomp_dec;

	// The displacement counts words, so it is sign extended and shifted by two
	assign bsr_disp = {{ext_w{dec_group[frontend_pkg::group_w-1]}},
		dec_group[frontend_pkg::disp_lsb +: frontend_pkg::disp_w], 2'b00};
	assign bsr_target = dec_addr + bsr_disp;

	// ========================================================================
	// Kill sources
	// ========================================================================

	// A cache miss leaves nothing useful in the fetched group.
	// Micro-code does not read the cache line, so a miss then is harmless
	assign stomp_fet = !ihit && !micro_code_active;

	// Recovery covers every state from checkpoint restore to the last done state
	assign in_recovery = (branch_state >= frontend_pkg::bs_chkpt_restore)
		&& (branch_state <= frontend_pkg::bs_done2);

	// The group entering mux is killed by a miss, a call ahead of it or any recovery
	assign next_stomp_mux = stomp_fet || do_bsr || branchmiss || in_recovery;

	// The group moving from mux into decode was fetched right behind the call,
	// so the call kills it as well
	assign next_stomp_dec = stomp_mux || do_bsr || branchmiss || in_recovery;

	// Rename gets no call term because the call itself is the group moving there
	assign next_stomp_ren = stomp_dec || branchmiss || in_recovery;

	// A group that reaches the queue during recovery was already renamed
	assign next_stomp_quem = branchmiss || in_recovery;

	// ========================================================================
	// Flag registers
	// ========================================================================

	// Every flag starts high so nothing from before reset leaks out.
	// A flag holds with its stage when that stage does not advance
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_mux <= 1'b1;
			stomp_dec <= 1'b1;
		end else if (advance_pipeline) begin
			stomp_mux <= next_stomp_mux;
			stomp_dec <= next_stomp_dec;
		end
	end

	// Rename belongs to the second segment.
	// If only that segment moves then decode did not hand over a group,
	// and rename takes a bubble that is dead by definition
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_ren <= 1'b1;
		end else if (advance_pipeline_seg2) begin
			if (!advance_pipeline) begin
				stomp_ren <= 1'b1;
			end else begin
				stomp_ren <= next_stomp_ren;
			end
		end
	end

	// The queue flags travel with the queue register.
	// stomp_que only says the group died before rename and can be dropped,
	// while stomp_quem says a renamed group must become a copy target
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_que <= 1'b1;
			stomp_quem <= 1'b1;
		end else if (advance_pipeline_seg2) begin
			stomp_que <= stomp_ren;
			stomp_quem <= next_stomp_quem;
		end
	end

endmodule

// ==== pipe_stage.sv ====
// Stage register for any packed payload. The bubble input only matters
// together with load, and a bubble is loaded as all zeros.
`timescale 1ns/1ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic bubble,
	input  payload_t in_payload,
	output payload_t out_payload
);

	// ========================================================================
	// Stage register
	// ========================================================================

	// The stage holds while load is low, which is how a stall reaches it.
	// A bubble writes zeros so a dead slot never carries stale wrong-path data,
	// even though its stomp flag already marks it
	always_ff @(posedge clk) begin
		if (rst) begin
			out_payload <= '0;
		end else if (load) begin
			if (bubble) begin
				out_payload <= '0;
			end else begin
				out_payload <= in_payload;
			end
		end
	end

endmodule

// ==== queue_stage.sv ====
// Queue stage. An entry is presented for exactly one cycle after each seg2 advance
// and is never held, so the consumer must take it in that cycle.
`timescale 1ns/1ps

module queue_stage (
	input  logic clk,
	input  logic rst,
	input  logic advance_pipeline_seg2,
	input  logic stomp_que,
	input  logic stomp_quem,
	input  frontend_pkg::rename_packet_t ren_payload,
	output logic que_valid,
	output logic que_copy_target,
	output logic [frontend_pkg::addr_w-1:0] que_addr,
	output logic [frontend_pkg::group_w-1:0] que_group
);

	// High for the cycle right after the queue register was loaded
	logic que_loaded;

	// ========================================================================
	// Queue register
	// ========================================================================

	// Address and group are plain payload.
	// Only the call flag stays behind since the queue does not use it
	always_ff @(posedge clk) begin
		if (advance_pipeline_seg2) begin
			que_addr <= ren_payload.addr;
			que_group <= ren_payload.group;
		end
	end

	// Marks a fresh load so that a held register is not queued twice
	always_ff @(posedge clk) begin
		if (rst) begin
			que_loaded <= 1'b0;
		end else begin
			que_loaded <= advance_pipeline_seg2;
		end
	end

	// ========================================================================
	// Entry type
	// ========================================================================

	// The stomp flags are loaded on the same edge as the payload, so they
	// describe exactly the group now in the register.
	// A group stomped before rename never took a rename slot and is simply dropped
	assign que_valid = que_loaded && !stomp_que;

	// A renamed group caught by a branch miss or recovery still has to be queued.
	// It becomes a copy target, which only releases its renamed register
	assign que_copy_target = que_valid && stomp_quem;

endmodule

// ==== frontend_top.sv ====
// Front end from fetch to the dispatch queue. advance_pipeline must only be high
// together with advance_pipeline_seg2, or the decode group is lost.
`timescale 1ns/1ps

module frontend_top #(
	parameter logic [frontend_pkg::addr_w-1:0] reset_addr = 32'h0000_1000
) (
	input  logic clk,
	input  logic rst,
	input  logic ihit,
	input  logic [frontend_pkg::group_w-1:0] group,
	input  logic advance_pipeline,
	input  logic advance_pipeline_seg2,
	input  logic micro_code_active,
	input  logic branchmiss,
	input  logic [frontend_pkg::addr_w-1:0] branch_target,
	output logic [frontend_pkg::addr_w-1:0] fetch_addr,
	output logic que_valid,
	output logic que_copy_target,
	output logic [frontend_pkg::addr_w-1:0] que_addr,
	output logic [frontend_pkg::group_w-1:0] que_group
);

	// Call redirect
	logic do_bsr;
	logic [frontend_pkg::addr_w-1:0] bsr_target;

	// Recovery state and stomp flags
	frontend_pkg::branch_state_t branch_state;
	logic stomp_mux;
	logic stomp_dec;
	logic stomp_ren;
	logic stomp_que;
	logic stomp_quem;

	// Stage payloads
	frontend_pkg::fetch_packet_t mux_in;
	frontend_pkg::fetch_packet_t mux_pkt;
	frontend_pkg::fetch_packet_t dec_pkt;
	frontend_pkg::rename_packet_t ren_in;
	frontend_pkg::rename_packet_t ren_pkt;

	// ========================================================================
	// Fetch and recovery
	// ========================================================================

	fetch_stage #(
		.reset_addr(reset_addr)
	) i_fetch_stage (
		.clk(clk),
		.rst(rst),
		.advance_pipeline(advance_pipeline),
		.ihit(ihit),
		.do_bsr(do_bsr),
		.bsr_target(bsr_target),
		.branchmiss(branchmiss),
		.branch_target(branch_target),
		.fetch_addr(fetch_addr)
	);

	branch_recovery_fsm i_branch_recovery_fsm (
		.clk(clk),
		.rst(rst),
		.branchmiss(branchmiss),
		.branch_state(branch_state)
	);

	// The decode group feeds the call check inside the stomp unit
	stomp_unit i_stomp_unit (
		.clk(clk),
		.rst(rst),
		.ihit(ihit),
		.advance_pipeline(advance_pipeline),
		.advance_pipeline_seg2(advance_pipeline_seg2),
		.micro_code_active(micro_code_active),
		.branchmiss(branchmiss),
		.branch_state(branch_state),
		.dec_opcode(dec_pkt.group[frontend_pkg::opcode_lsb +: frontend_pkg::opcode_w]),
		.dec_addr(dec_pkt.addr),
		.dec_group(dec_pkt.group),
		.do_bsr(do_bsr),
		.bsr_target(bsr_target),
		.stomp_mux(stomp_mux),
		.stomp_dec(stomp_dec),
		.stomp_ren(stomp_ren),
		.stomp_que(stomp_que),
		.stomp_quem(stomp_quem)
	);

	// ========================================================================
	// Stage registers
	// ========================================================================

	// The cache answers for the current fetch address in the same cycle
	assign mux_in = '{addr: fetch_addr, group: group};

	pipe_stage #(
		.payload_t(frontend_pkg::fetch_packet_t)
	) i_mux_stage (
		.clk(clk),
		.rst(rst),
		.load(advance_pipeline),
		.bubble(1'b0),
		.in_payload(mux_in),
		.out_payload(mux_pkt)
	);

	pipe_stage #(
		.payload_t(frontend_pkg::fetch_packet_t)
	) i_dec_stage (
		.clk(clk),
		.rst(rst),
		.load(advance_pipeline),
		.bubble(1'b0),
		.in_payload(mux_pkt),
		.out_payload(dec_pkt)
	);

	// Rename picks up the call flag that decode produced for this group
	assign ren_in = '{addr: dec_pkt.addr, group: dec_pkt.group, is_call: do_bsr};

	// Seg2 alone moves rename, and without seg1 it takes a bubble
	pipe_stage #(
		.payload_t(frontend_pkg::rename_packet_t)
	) i_ren_stage (
		.clk(clk),
		.rst(rst),
		.load(advance_pipeline_seg2),
		.bubble(!advance_pipeline),
		.in_payload(ren_in),
		.out_payload(ren_pkt)
	);

	// ========================================================================
	// Queue
	// ========================================================================

	queue_stage i_queue_stage (
		.clk(clk),
		.rst(rst),
		.advance_pipeline_seg2(advance_pipeline_seg2),
		.stomp_que(stomp_que),
		.stomp_quem(stomp_quem),
		.ren_payload(ren_pkt),
		.que_valid(que_valid),
		.que_copy_target(que_copy_target),
		.que_addr(que_addr),
		.que_group(que_group)
	);

endmodule

// ==== tb_frontend.sv ====
// Directed testbench of the front end. It plays the cache and answers each fetch address
// in the same cycle with a random group. advance_pipeline is never high without seg2.
`timescale 1ns/1ps

module tb_frontend;

	localparam int clk_period = 10;
	localparam int reset_cycles = 10;
	localparam logic [frontend_pkg::addr_w-1:0] reset_addr = 32'h0000_1000;

	// ========================================================================
	// Test lengths in steps, which also size the watchdog
	// ========================================================================

	localparam int len_fill = 16;
	localparam int len_miss = 16;
	localparam int len_call = 16;
	localparam int len_bmiss = 20;
	localparam int len_stall = 20;
	localparam int margin_cycles = 50;
	localparam int total_steps = len_fill + len_miss + len_call + len_bmiss + len_stall;

	logic clk = 1'b0;
	logic rst;
	logic ihit;
	logic [frontend_pkg::group_w-1:0] group;
	logic advance_pipeline;
	logic advance_pipeline_seg2;
	logic micro_code_active;
	logic branchmiss;
	logic [frontend_pkg::addr_w-1:0] branch_target;
	logic [frontend_pkg::addr_w-1:0] fetch_addr;
	logic que_valid;
	logic que_copy_target;
	logic [frontend_pkg::addr_w-1:0] que_addr;
	logic [frontend_pkg::group_w-1:0] que_group;

	// Reference model with the predicted fetch address and a live flag per stage
	logic [31:0] m_fetch = reset_addr;
	logic mux_live = 1'b0;
	logic dec_live = 1'b0;
	logic ren_live = 1'b0;
	logic q_live = 1'b0;
	logic q_fresh = 1'b0;
	logic q_quem = 1'b1;
	logic [31:0] mux_addr = '0;
	logic [31:0] mux_grp = '0;
	logic [31:0] dec_addr = '0;
	logic [31:0] dec_grp = '0;
	logic [31:0] ren_addr = '0;
	logic [31:0] ren_grp = '0;
	logic [31:0] q_addr = '0;
	logic [31:0] q_grp = '0;
	// Recovery cycles still to come, three after a branch miss
	int rec_left = 0;

	integer seed = 32'h4691_3183;
	int error_count = 0;
	int check_count = 0;
	int n_valid = 0;
	int n_copy = 0;
	logic [31:0] call_addr;
	logic [31:0] call_word;

	always #(clk_period / 2) clk = ~clk;

	frontend_top #(
		.reset_addr(reset_addr)
	) i_frontend_top (
		.clk(clk),
		.rst(rst),
		.ihit(ihit),
		.group(group),
		.advance_pipeline(advance_pipeline),
		.advance_pipeline_seg2(advance_pipeline_seg2),
		.micro_code_active(micro_code_active),
		.branchmiss(branchmiss),
		.branch_target(branch_target),
		.fetch_addr(fetch_addr),
		.que_valid(que_valid),
		.que_copy_target(que_copy_target),
		.que_addr(que_addr),
		.que_group(que_group)
	);

	task automatic compare_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// Upper 25 bits of a call are a signed word displacement from its own address
	function automatic logic [31:0] call_target(input logic [31:0] addr,
		input logic [31:0] word);
		return addr + ({{7{word[31]}}, word[31:7]} << 2);
	endfunction

	// ========================================================================
	// One clock step: advance the model, drive the next cycle, check outputs
	// ========================================================================

	task automatic step(input logic ih, input logic a1, input logic a2, input logic mc,
		input logic bm, input logic [31:0] bt, input logic mk_call, input logic [24:0] disp);
		logic [31:0] g;
		logic [31:0] call_dest;
		logic call_now;
		logic kill;
		logic exp_valid;
		@(posedge clk);
		// The inputs still hold the cycle that the DUT has just sampled
		call_now = dec_live && (dec_grp[6:0] == frontend_pkg::op_bsr);
		call_dest = call_target(dec_addr, dec_grp);
		kill = branchmiss || (rec_left != 0);
		// Stages move back to front so each one takes the old content ahead of it
		if (advance_pipeline_seg2) begin
			q_live = ren_live;
			q_addr = ren_addr;
			q_grp = ren_grp;
			q_quem = kill;
			// Without seg1 rename takes a dead bubble
			ren_live = advance_pipeline && dec_live && !kill;
			ren_addr = advance_pipeline ? dec_addr : '0;
			ren_grp = advance_pipeline ? dec_grp : '0;
		end
		q_fresh = advance_pipeline_seg2;
		if (advance_pipeline) begin
			dec_live = mux_live && !call_now && !kill;
			dec_addr = mux_addr;
			dec_grp = mux_grp;
			mux_live = (ihit || micro_code_active) && !call_now && !kill;
			mux_addr = m_fetch;
			mux_grp = group;
		end
		if (branchmiss) begin
			m_fetch = branch_target;
		end else if (advance_pipeline && call_now) begin
			m_fetch = call_dest;
		end else if (advance_pipeline && ihit) begin
			m_fetch = m_fetch + frontend_pkg::group_bytes;
		end
		if (branchmiss) begin
			rec_left = 3;
		end else if (rec_left != 0) begin
			rec_left--;
		end

		// Random groups never look like a call
		g = $random(seed);
		if (g[6:0] == frontend_pkg::op_bsr) begin
			g[0] = ~g[0];
		end
		if (mk_call) begin
			g = {disp, frontend_pkg::op_bsr};
			call_addr = m_fetch;
			call_word = g;
		end
		ihit <= ih;
		advance_pipeline <= a1;
		advance_pipeline_seg2 <= a2;
		micro_code_active <= mc;
		branchmiss <= bm;
		branch_target <= bt;
		group <= g;

		@(negedge clk);
		exp_valid = q_fresh && q_live;
		compare_value("fetch_addr", fetch_addr, m_fetch);
		compare_value("que_valid", que_valid, exp_valid);
		compare_value("que_copy_target", que_copy_target, exp_valid && q_quem);
		if (exp_valid) begin
			compare_value("que_addr", que_addr, q_addr);
			compare_value("que_group", que_group, q_grp);
		end
		if (que_valid === 1'b1) n_valid++;
		if (que_copy_target === 1'b1) n_copy++;
	endtask

	task automatic run_normal(input int n);
		for (int i = 0; i < n; i++) begin
			step(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
		end
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic fill_and_stream();
		int v0;
		int c0;
		v0 = n_valid;
		c0 = n_copy;
		run_normal(len_fill);
		// The first group needs four edges to reach the queue
		compare_value("valid entry count", n_valid - v0, len_fill - 4);
		compare_value("copy target count", n_copy - c0, 0);
	endtask

	task automatic ihit_gaps();
		logic [31:0] held;
		run_normal(2);
		held = m_fetch;
		repeat (3) step(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
		// Micro-code keeps a missed slot alive, yet the address still holds
		step(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		compare_value("fetch_addr", fetch_addr, held + frontend_pkg::group_bytes);
		run_normal(len_miss - 6);
	endtask

	task automatic call_redirect();
		run_normal(2);
		// A backward call of sixteen words
		step(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b1, 25'h1ff_fff0);
		run_normal(3);
		compare_value("fetch_addr", fetch_addr, call_target(call_addr, call_word));
		run_normal(len_call - 6);
	endtask

	task automatic branch_miss_recovery();
		int c0;
		int p0;
		run_normal(6);
		c0 = n_copy;
		step(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0000_8000, 1'b0, '0);
		p0 = n_valid - n_copy;
		run_normal(len_bmiss - 7);
		compare_value("copy target seen", n_copy > c0, 1);
		compare_value("valid entries resumed", (n_valid - n_copy) > p0, 1);
	endtask

	task automatic seg1_stall();
		int v0;
		run_normal(6);
		v0 = n_valid;
		repeat (4) step(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
		// The first stall step still samples a full advance.
		// The group then in rename follows it into the queue and every later slot is a bubble
		compare_value("valid during stall", n_valid - v0, 2);
		run_normal(len_stall - 10);
	endtask

	initial begin
		rst = 1'b1;
		ihit = 1'b0;
		group = '0;
		advance_pipeline = 1'b0;
		advance_pipeline_seg2 = 1'b0;
		micro_code_active = 1'b0;
		branchmiss = 1'b0;
		branch_target = '0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		fill_and_stream();
		ihit_gaps();
		call_redirect();
		branch_miss_recovery();
		seg1_stall();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(clk_period * (reset_cycles + total_steps + margin_cycles));
		$display("Watchdog expired before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
frontend_pkg.sv
fetch_stage.sv
branch_recovery_fsm.sv
stomp_unit.sv
pipe_stage.sv
queue_stage.sv
frontend_top.sv
tb_frontend.sv
